/* source/apogeo_pkg.sv */
package apogeo_pkg;

    // register index and register value.
    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] data_word_t;

    // major opcodes that read source registers.
    localparam logic [6:0] opc_op      = 7'b0110011;
    localparam logic [6:0] opc_op_imm  = 7'b0010011;
    localparam logic [6:0] opc_branch  = 7'b1100011;
    localparam logic [6:0] opc_op_fp   = 7'b1010011;
    // fused multiply-add family, the only R4 instructions.
    localparam logic [6:0] opc_fmadd   = 7'b1000011;
    localparam logic [6:0] opc_fmsub   = 7'b1000111;
    localparam logic [6:0] opc_fnmsub  = 7'b1001011;
    localparam logic [6:0] opc_fnmadd  = 7'b1001111;

    // which register class and how many sources an instruction reads.
    typedef enum logic [1:0] {
        cls_none   = 2'd0,
        cls_int    = 2'd1,
        cls_float2 = 2'd2,
        cls_float3 = 2'd3
    } operand_class_t;

    // standard R-type layout.
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_type_t;

    // R4 layout, funct7 splits into rs3 and fmt.
    typedef struct packed {
        reg_addr_t  rs3;
        logic [1:0] fmt;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r4_type_t;

    // one instruction word seen through either layout.
    typedef union packed {
        r_type_t  r;
        r4_type_t r4;
    } instr_u;

    // source request from the decoder, 18 bits.
    typedef struct packed {
        reg_addr_t      rs1;
        reg_addr_t      rs2;
        reg_addr_t      rs3;
        logic           float_sel;
        operand_class_t op_class;
    } src_req_t;

    // writeback request, 39 bits.
    typedef struct packed {
        logic       write;
        logic       float_sel;
        reg_addr_t  addr;
        data_word_t data;
    } wb_req_t;

    // operand bundle handed to execute, 99 bits.
    typedef struct packed {
        logic           valid;
        operand_class_t op_class;
        data_word_t     data_1;
        data_word_t     data_2;
        data_word_t     data_3;
    } issue_t;

endpackage : apogeo_pkg

/* source/operand_decoder.sv */
`timescale 1ns/1ns

module operand_decoder
    import apogeo_pkg::*;
#(
    parameter logic HAS_FPU = 1'b1
) (
    input  instr_u   instr_i,
    input  logic     instr_valid_i,
    output src_req_t src_o
);

    // class chosen for the current word.
    operand_class_t op_class;
    // classes given to floating-point opcodes.
    operand_class_t fp2_class;
    operand_class_t fp3_class;

    // without an fpu the floating-point opcodes read the integer bank.
    assign fp2_class = HAS_FPU ? cls_float2 : cls_int;
    assign fp3_class = HAS_FPU ? cls_float3 : cls_int;

    // opcode classification.
    always_comb begin
        if (!instr_valid_i) begin
            // no instruction, nothing to read.
            op_class = cls_none;
        end else begin
            case (instr_i.r.opcode)
                opc_op, opc_op_imm, opc_branch: begin
                    op_class = cls_int;
                end
                opc_op_fp: begin
                    op_class = fp2_class;
                end
                opc_fmadd, opc_fmsub, opc_fnmsub, opc_fnmadd: begin
                    op_class = fp3_class;
                end
                default: begin
                    // other opcodes still issue, reading integer rs1 and rs2.
                    op_class = cls_int;
                end
            endcase
        end
    end

    // source address extraction.
    always_comb begin
        src_o           = '0;
        src_o.op_class  = op_class;
        src_o.float_sel = (op_class == cls_float2) || (op_class == cls_float3);

        // rs1 and rs2 sit at the same place in both layouts.
        if (op_class != cls_none) begin
            src_o.rs1 = instr_i.r.rs1;
            src_o.rs2 = instr_i.r.rs2;
        end

        // upper bits are rs3 only in the R4 view.
        if (op_class == cls_float3) begin
            src_o.rs3 = instr_i.r4.rs3;
        end
    end

endmodule : operand_decoder

/* source/register_file.sv */
`timescale 1ns/1ns

module register_file
    import apogeo_pkg::*;
#(
    parameter logic HAS_FPU = 1'b1
) (
    input  logic       clk_i,
    input  src_req_t   src_i,
    input  wb_req_t    wb_i,
    output data_word_t read_data_1_o,
    output data_word_t read_data_2_o,
    output data_word_t read_data_3_o
);

    // integer banks hold identical data.
    // each bank feeds one read port, modelling 1W/2R distributed ram.
    data_word_t int_bank [2][32];

    // raw integer reads, x0 is masked later in the bypass.
    data_word_t int_operand_1;
    data_word_t int_operand_2;

    // floating-point reads, zero when the fpu is absent.
    data_word_t fp_operand_1;
    data_word_t fp_operand_2;
    data_word_t fp_operand_3;

    // integer write enable.
    logic int_write;

    // without an fpu a float-selected write lands in the integer bank.
    assign int_write = wb_i.write && !(wb_i.float_sel && HAS_FPU);

    // same word written into every integer bank.
    always_ff @(posedge clk_i) begin
        if (int_write) begin
            for (int b = 0; b < 2; b++) begin
                int_bank[b][wb_i.addr] <= wb_i.data;
            end
        end
    end

    // one bank per port.
    assign int_operand_1 = int_bank[0][src_i.rs1];
    assign int_operand_2 = int_bank[1][src_i.rs2];

    generate
        if (HAS_FPU) begin : g_fp_banks
            // three copies, one per source of the R4 instructions.
            data_word_t fp_bank [3][32];
            logic       fp_write;

            assign fp_write = wb_i.write && wb_i.float_sel;

            // f0 is an ordinary register, no masking.
            always_ff @(posedge clk_i) begin
                if (fp_write) begin
                    for (int b = 0; b < 3; b++) begin
                        fp_bank[b][wb_i.addr] <= wb_i.data;
                    end
                end
            end

            assign fp_operand_1 = fp_bank[0][src_i.rs1];
            assign fp_operand_2 = fp_bank[1][src_i.rs2];
            assign fp_operand_3 = fp_bank[2][src_i.rs3];
        end else begin : g_no_fp_banks
            // no floating-point storage.
            assign fp_operand_1 = '0;
            assign fp_operand_2 = '0;
            assign fp_operand_3 = '0;
        end
    endgenerate

    // class select on the read side.
    always_comb begin
        if (src_i.float_sel) begin
            read_data_1_o = fp_operand_1;
            read_data_2_o = fp_operand_2;
            read_data_3_o = fp_operand_3;
        end else begin
            read_data_1_o = int_operand_1;
            read_data_2_o = int_operand_2;
            // integer instructions have no third source.
            read_data_3_o = '0;
        end
    end

endmodule : register_file

/* source/operand_bypass.sv */
`timescale 1ns/1ns

module operand_bypass
    import apogeo_pkg::*;
#(
    parameter logic HAS_FPU = 1'b1
) (
    input  logic       clk_i,
    input  logic       rst_i,
    input  src_req_t   src_i,
    input  wb_req_t    wb_i,
    input  data_word_t read_data_1_i,
    input  data_word_t read_data_2_i,
    input  data_word_t read_data_3_i,
    output issue_t     issue_o
);

    // class of the writeback as the register file stores it.
    logic   wb_float;
    // bundle before the pipeline register.
    issue_t issue_d;

    // a float write folds into the integer bank when the fpu is absent.
    assign wb_float = wb_i.float_sel && HAS_FPU;

    // picks bank data or forwarded writeback data for one port.
    function automatic data_word_t select_operand(
        input reg_addr_t  addr,
        input data_word_t bank_data,
        input logic       float_sel,
        input logic       wb_is_float,
        input wb_req_t    wb
    );
        logic is_x0;
        logic hit;

        // integer x0 always reads zero, so it is never forwarded.
        is_x0 = !float_sel && (addr == '0);
        // same address and same class as a write this cycle.
        hit   = wb.write && (wb_is_float == float_sel) && (wb.addr == addr);

        if (is_x0) begin
            return '0;
        end else if (hit) begin
            return wb.data;
        end
        return bank_data;
    endfunction

    // operand assembly.
    always_comb begin
        issue_d          = '0;
        issue_d.valid    = (src_i.op_class != cls_none);
        issue_d.op_class = src_i.op_class;

        // every issuing class reads the first two ports.
        if (src_i.op_class != cls_none) begin
            issue_d.data_1 = select_operand(src_i.rs1, read_data_1_i, src_i.float_sel,
                                            wb_float, wb_i);
            issue_d.data_2 = select_operand(src_i.rs2, read_data_2_i, src_i.float_sel,
                                            wb_float, wb_i);
        end

        // third port only for R4 instructions.
        if (src_i.op_class == cls_float3) begin
            issue_d.data_3 = select_operand(src_i.rs3, read_data_3_i, src_i.float_sel,
                                            wb_float, wb_i);
        end
    end

    // the single pipeline stage of the slice.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            issue_o <= '0;
        end else begin
            // no back-pressure, overwritten every cycle.
            issue_o <= issue_d;
        end
    end

endmodule : operand_bypass

/* source/operand_fetch_top.sv */
`timescale 1ns/1ns

module operand_fetch_top
    import apogeo_pkg::*;
#(
    parameter logic HAS_FPU = 1'b1
) (
    input  logic    clk_i,
    input  logic    rst_i,
    input  logic    instr_valid_i,
    input  instr_u  instr_i,
    input  wb_req_t wb_i,
    output issue_t  issue_o
);

    // decoded source request, shared by storage and bypass.
    src_req_t   src_req;
    // raw bank reads.
    data_word_t read_data_1;
    data_word_t read_data_2;
    data_word_t read_data_3;

    // instruction word to addresses and class.
    operand_decoder #(
        .HAS_FPU       (HAS_FPU)
    ) u_decoder (
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .src_o         (src_req)
    );

    // banked storage, written by the writeback stage.
    register_file #(
        .HAS_FPU       (HAS_FPU)
    ) u_regfile (
        .clk_i         (clk_i),
        .src_i         (src_req),
        .wb_i          (wb_i),
        .read_data_1_o (read_data_1),
        .read_data_2_o (read_data_2),
        .read_data_3_o (read_data_3)
    );

    // forwarding and the issue register.
    operand_bypass #(
        .HAS_FPU       (HAS_FPU)
    ) u_bypass (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .src_i         (src_req),
        .wb_i          (wb_i),
        .read_data_1_i (read_data_1),
        .read_data_2_i (read_data_2),
        .read_data_3_i (read_data_3),
        .issue_o       (issue_o)
    );

endmodule : operand_fetch_top

/* tb/operand_fetch_props.sv */
`timescale 1ns/1ns

module operand_fetch_props
    import apogeo_pkg::*;
(
    input logic   clk_i,
    input logic   rst_i,
    input logic   instr_valid_i,
    input issue_t issue_i
);

    // a reset cycle leaves an empty bundle.
    property p_reset_clears;
        @(posedge clk_i) rst_i |=> !issue_i.valid;
    endproperty

    // one cycle latency, no instruction is dropped or invented.
    property p_valid_follows;
        @(posedge clk_i) disable iff (rst_i)
            !rst_i |=> (issue_i.valid == $past(instr_valid_i));
    endproperty

    // only R4 instructions carry a third operand.
    property p_data_3_zero;
        @(posedge clk_i) disable iff (rst_i)
            (issue_i.op_class != cls_float3) |-> (issue_i.data_3 == '0);
    endproperty

    a_reset_clears: assert property (p_reset_clears)
        else $error("issue valid high in the cycle after reset");

    a_valid_follows: assert property (p_valid_follows)
        else $error("issue valid differs from last cycle instruction valid");

    a_data_3_zero: assert property (p_data_3_zero)
        else $error("data 3 nonzero for a class without a third source");

endmodule : operand_fetch_props

bind operand_fetch_top operand_fetch_props u_props (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .instr_valid_i (instr_valid_i),
    .issue_i       (issue_o)
);

/* tb/operand_fetch_tb.sv */
`timescale 1ns/1ns

module operand_fetch_tb
    import apogeo_pkg::*;
();

    // driven cycles of all tests including the idle drains.
    localparam int test_cycles    = 14 + 68 + 98 + 42 + 38 + 402;
    localparam int timeout_cycles = test_cycles + 100;
    localparam wb_req_t wb_idle   = '0;

    logic    clk_i;
    logic    rst_i;
    logic    instr_valid_i;
    instr_u  instr_i;
    wb_req_t wb_i;
    issue_t  issue_o;

    // stimulus source and the committed register state.
    logic [31:0] lfsr_state = 32'he749_3678;
    data_word_t  int_shadow [32];
    data_word_t  fp_shadow  [32];

    // bundle expected on the next edge.
    issue_t exp_issue;
    string  exp_name;
    logic   exp_ready = 1'b0;
    string  test_name = "reset";

    int cycle_count = 0;
    int check_count = 0;
    int error_count = 0;
    int test_errors_start = 0;
    int tests_run = 0;
    int tests_clean = 0;

    operand_fetch_top #(
        .HAS_FPU       (1'b1)
    ) u_dut (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .wb_i          (wb_i),
        .issue_o       (issue_o)
    );

    always #20 clk_i = ~clk_i;

    // fibonacci lfsr with taps 32 22 2 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // n fresh bits with one step per bit.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic logic [6:0] pick_opcode(input logic [2:0] sel);
        case (sel)
            3'd0: return opc_op;
            3'd1: return opc_op_imm;
            3'd2: return opc_branch;
            3'd3: return opc_op_fp;
            3'd4: return opc_fmadd;
            3'd5: return opc_fmsub;
            3'd6: return opc_fnmsub;
            default: return opc_fnmadd;
        endcase
    endfunction

    // rs3 always lands in the top bits.
    // rd and funct3 are noise.
    function automatic instr_u make_instr(input logic [6:0] opcode, input reg_addr_t rs1,
                                          input reg_addr_t rs2, input reg_addr_t rs3);
        instr_u word;
        word.r4.rs3    = rs3;
        word.r4.fmt    = 2'(take_bits(2));
        word.r4.rs2    = rs2;
        word.r4.rs1    = rs1;
        word.r4.funct3 = 3'(take_bits(3));
        word.r4.rd     = reg_addr_t'(take_bits(5));
        word.r4.opcode = opcode;
        return word;
    endfunction

    function automatic wb_req_t make_wb(input logic write, input logic fp,
                                        input reg_addr_t addr, input data_word_t data);
        wb_req_t wb;
        wb.write     = write;
        wb.float_sel = fp;
        wb.addr      = addr;
        wb.data      = data;
        return wb;
    endfunction

    // x0 reads zero.
    // a same-class write this cycle wins over stored state.
    function automatic data_word_t expected_operand(input reg_addr_t addr, input logic fp,
                                                    input wb_req_t wb);
        if (!fp && addr == '0) begin
            return '0;
        end
        if (wb.write && wb.float_sel == fp && wb.addr == addr) begin
            return wb.data;
        end
        return fp ? fp_shadow[addr] : int_shadow[addr];
    endfunction

    function automatic issue_t expected_issue(input logic valid, input instr_u word,
                                              input wb_req_t wb);
        logic [31:0] raw;
        issue_t      exp;
        logic        fp;
        raw = word;
        exp = '0;
        if (!valid) begin
            return exp;
        end
        // integer opcodes and anything unknown read integer rs1 and rs2.
        case (raw[6:0])
            opc_op_fp: exp.op_class = cls_float2;
            opc_fmadd, opc_fmsub, opc_fnmsub, opc_fnmadd: exp.op_class = cls_float3;
            default: exp.op_class = cls_int;
        endcase
        exp.valid  = 1'b1;
        fp         = (exp.op_class != cls_int);
        exp.data_1 = expected_operand(raw[19:15], fp, wb);
        exp.data_2 = expected_operand(raw[24:20], fp, wb);
        if (exp.op_class == cls_float3) begin
            exp.data_3 = expected_operand(raw[31:27], fp, wb);
        end
        return exp;
    endfunction

    task automatic check_value(input string name, input logic [98:0] expected,
                               input logic [98:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // inputs are stable at the falling edge.
    // check the previous bundle, then predict this one and commit its write.
    always @(negedge clk_i) begin
        if (exp_ready) begin
            check_value(exp_name, exp_issue, issue_o);
        end
        exp_issue = rst_i ? '0 : expected_issue(instr_valid_i, instr_i, wb_i);
        exp_name  = test_name;
        exp_ready = 1'b1;
        if (wb_i.write && wb_i.float_sel) begin
            fp_shadow[wb_i.addr] = wb_i.data;
        end else if (wb_i.write) begin
            int_shadow[wb_i.addr] = wb_i.data;
        end
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count > timeout_cycles) begin
            $display("timeout: stimulus still running after %0d cycles", cycle_count);
            $display("tests failed");
            $finish;
        end
    end

    task automatic drive(input logic valid, input instr_u word, input wb_req_t wb);
        @(posedge clk_i);
        instr_valid_i <= valid;
        instr_i       <= word;
        wb_i          <= wb;
    endtask

    task automatic begin_test(input string name);
        test_name         = name;
        test_errors_start = error_count;
    endtask

    // two idle cycles flush the last bundle through the compare.
    task automatic end_test();
        int errors;
        drive(1'b0, '0, wb_idle);
        drive(1'b0, '0, wb_idle);
        errors = error_count - test_errors_start;
        tests_run++;
        if (errors == 0) begin
            tests_clean++;
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d mismatches", test_name, errors);
        end
    endtask

    task automatic run_reset_test();
        begin_test("reset");
        repeat (4) @(posedge clk_i);
        rst_i <= 1'b0;
        // random words with valid low.
        for (int n = 0; n < 8; n++) begin
            drive(1'b0, instr_u'(take_bits(32)), wb_idle);
        end
        end_test();
    endtask

    task automatic run_int_rw_test();
        logic [6:0] opcode;
        begin_test("int_write_read");
        for (int i = 0; i < 32; i++) begin
            drive(1'b0, '0, make_wb(1'b1, 1'b0, reg_addr_t'(i), take_bits(32)));
        end
        for (int i = 0; i < 32; i++) begin
            opcode = (i % 3 == 0) ? opc_op : (i % 3 == 1) ? opc_op_imm : opc_branch;
            drive(1'b1, make_instr(opcode, reg_addr_t'(i), reg_addr_t'(take_bits(5)), '1),
                  wb_idle);
        end
        // x0 keeps reading zero after a stored write.
        drive(1'b0, '0, make_wb(1'b1, 1'b0, '0, take_bits(32)));
        drive(1'b1, make_instr(opc_op, '0, '0, '1), wb_idle);
        end_test();
    endtask

    task automatic run_fp_iso_test();
        begin_test("fp_isolation");
        for (int i = 0; i < 32; i++) begin
            drive(1'b0, '0, make_wb(1'b1, 1'b1, reg_addr_t'(i), take_bits(32)));
        end
        // each cycle writes the other class at the rs1 address.
        // rs2 reads the address that took the other-class write one cycle earlier.
        for (int i = 0; i < 16; i++) begin
            drive(1'b1, make_instr(opc_op_fp, reg_addr_t'(i), reg_addr_t'(i - 1), '0),
                  make_wb(1'b1, 1'b0, reg_addr_t'(i), take_bits(32)));
        end
        for (int i = 0; i < 16; i++) begin
            drive(1'b1, make_instr(opc_op, reg_addr_t'(i), reg_addr_t'(i - 1), '0),
                  make_wb(1'b1, 1'b1, reg_addr_t'(i), take_bits(32)));
        end
        // read back both classes including f0.
        for (int i = 0; i < 16; i++) begin
            drive(1'b1, make_instr(opc_op, reg_addr_t'(i), reg_addr_t'(i), '0), wb_idle);
            drive(1'b1, make_instr(opc_op_fp, reg_addr_t'(i), reg_addr_t'(i), '0), wb_idle);
        end
        end_test();
    endtask

    task automatic run_r4_test();
        begin_test("r4_operands");
        for (int i = 0; i < 32; i++) begin
            drive(1'b1, make_instr(pick_opcode(3'(4 + i % 4)), reg_addr_t'(take_bits(5)),
                  reg_addr_t'(take_bits(5)), reg_addr_t'(take_bits(5))), wb_idle);
        end
        // upper bits set but only two sources.
        for (int i = 0; i < 8; i++) begin
            drive(1'b1, make_instr(opc_op_fp, reg_addr_t'(take_bits(5)),
                  reg_addr_t'(take_bits(5)), '1), wb_idle);
        end
        end_test();
    endtask

    task automatic run_forward_test();
        reg_addr_t addr;
        begin_test("forwarding");
        for (int i = 0; i < 16; i++) begin
            addr = reg_addr_t'(take_bits(5));
            if (addr == '0) begin
                addr = 5'd1;
            end
            drive(1'b1, make_instr(opc_op, addr, reg_addr_t'(take_bits(5)), '0),
                  make_wb(1'b1, 1'b0, addr, take_bits(32)));
        end
        for (int i = 0; i < 16; i++) begin
            addr = reg_addr_t'(take_bits(5));
            drive(1'b1, make_instr(opc_fmadd, addr, reg_addr_t'(take_bits(5)), addr),
                  make_wb(1'b1, 1'b1, addr, take_bits(32)));
        end
        for (int i = 0; i < 4; i++) begin
            drive(1'b1, make_instr(opc_op, '0, '0, '0), make_wb(1'b1, 1'b0, '0, take_bits(32)));
        end
        end_test();
    endtask

    task automatic run_random_test();
        logic      valid;
        logic      hit;
        reg_addr_t rs1;
        instr_u    word;
        wb_req_t   wb;
        begin_test("random_stream");
        for (int n = 0; n < 400; n++) begin
            valid = (take_bits(2) != '0);
            rs1   = reg_addr_t'(take_bits(5));
            word  = make_instr(pick_opcode(3'(take_bits(3))), rs1, reg_addr_t'(take_bits(5)),
                               reg_addr_t'(take_bits(5)));
            // half the writes aim at rs1 so forwarding is common.
            hit   = 1'(take_bits(1));
            wb    = make_wb(1'(take_bits(1)), 1'(take_bits(1)),
                            hit ? rs1 : reg_addr_t'(take_bits(5)), take_bits(32));
            drive(valid, word, wb);
        end
        end_test();
    endtask

    initial begin
        clk_i         = 1'b0;
        rst_i         = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        wb_i          = '0;
        run_reset_test();
        run_int_rw_test();
        run_fp_iso_test();
        run_r4_test();
        run_forward_test();
        run_random_test();
        $display("summary: %0d checks, %0d mismatches, %0d of %0d tests clean",
                 check_count, error_count, tests_clean, tests_run);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule : operand_fetch_tb

/* files.f */
source/apogeo_pkg.sv
source/operand_decoder.sv
source/register_file.sv
source/operand_bypass.sv
source/operand_fetch_top.sv
tb/operand_fetch_props.sv
tb/operand_fetch_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the operand fetch testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

build_dir=build
obj_dir="$build_dir/obj_dir"
log_file="$build_dir/sim.log"

mkdir -p "$build_dir"
if [ $? -ne 0 ]; then
    echo "cannot create $build_dir"
    exit 1
fi

verilator --binary --timing --assert \
    --top-module operand_fetch_tb \
    -Mdir "$obj_dir" \
    -f files.f
if [ $? -ne 0 ]; then
    echo "verilator compile step returned an error"
    exit 1
fi

"./$obj_dir/Voperand_fetch_tb" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "all tests passed" "$log_file"; then
    exit 0
fi
echo "pass line not found in $log_file"
exit 1
